/* common/rvv_dispatch_pkg.sv */
// Shared types for the two-wide vector dispatch stage.
// Sized for a 64-bit VLEN, 32 vector registers and an 8-entry ROB.
package rvv_dispatch_pkg;

    // Dispatch width and shared resources
    localparam int num_dp_uop = 2;
    localparam int num_vrf_rd = 4;
    localparam int rob_depth  = 8;
    localparam int rob_idx_w  = 3;

    localparam int vlen       = 64;
    localparam int vreg_idx_w = 5;
    localparam int funct_w    = 6;
    localparam int vrf_port_w = $clog2(num_vrf_rd);

    typedef logic [vlen-1:0]       vlen_t;
    typedef logic [vreg_idx_w-1:0] vreg_idx_t;
    typedef logic [rob_idx_w-1:0]  rob_idx_t;
    typedef logic [vrf_port_w-1:0] vrf_port_t;

    // Operand shape of a uop, decides which sources are read
    typedef enum logic [1:0] {
        VVV = 2'd0,
        VV  = 2'd1,
        VX  = 2'd2
    } uop_class_e;

    typedef enum logic {
        ALU = 1'b0,
        MUL = 1'b1
    } exe_unit_e;

    // One entry from the uop queue
    typedef struct packed {
        uop_class_e       uop_class;
        exe_unit_e        exe_unit;
        vreg_idx_t        vs1;
        vreg_idx_t        vs2;
        vreg_idx_t        vd;
        logic [funct_w-1:0] funct6;
        logic [2:0]       funct3;
        logic [31:0]      rs1_data;
        logic             vm;
        logic             last_uop;
    } uop_t;

    typedef struct packed {
        logic      valid;
        logic      w_valid;
        vreg_idx_t w_index;
        vlen_t     w_data;
    } rob_entry_t;

    // Youngest ROB producer of each source, plus the stall verdict
    typedef struct packed {
        logic     vs1_hit;
        rob_idx_t vs1_idx;
        logic     vs2_hit;
        rob_idx_t vs2_idx;
        logic     vd_hit;
        rob_idx_t vd_idx;
        logic     stall;
    } src_hit_t;

    typedef struct packed {
        vrf_port_t vd_port;
        vrf_port_t vs1_port;
        vrf_port_t vs2_port;
    } port_sel_t;

    typedef struct packed {
        logic vd;
        logic vs1;
        logic vs2;
    } src_use_t;

    typedef struct packed {
        vlen_t vs1;
        vlen_t vs2;
        vlen_t vd;
    } uop_opnd_t;

    typedef struct packed {
        rob_idx_t           rob_entry;
        logic [funct_w-1:0] funct6;
        logic [2:0]         funct3;
        logic               vm;
        vlen_t              vs1_data;
        logic               vs1_data_valid;
        vlen_t              vs2_data;
        logic               vs2_data_valid;
        vlen_t              vd_data;
        logic               vd_data_valid;
        logic [31:0]        rs1_data;
    } alu_rs_t;

    // The MUL station takes the ALU payload layout unchanged
    typedef alu_rs_t mul_rs_t;

    typedef struct packed {
        vreg_idx_t w_index;
        logic      last_uop;
    } dp2rob_t;

    // vs2 is always read, vs1 for VVV and VV, vd only for VVV
    function automatic src_use_t src_used(input uop_class_e cls);
        src_use_t rd;
        rd.vs2 = 1'b1;
        rd.vs1 = (cls == VVV) || (cls == VV);
        rd.vd  = (cls == VVV);
        return rd;
    endfunction

endpackage

/* dispatch_hazard/raw_rob_check.sv */
// RAW check of one uop against the whole ROB; rob_tail is the slot the next uop gets.
module raw_rob_check (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  rvv_dispatch_pkg::uop_t                                 uop,
    input  rvv_dispatch_pkg::rob_idx_t                             rob_tail,
    input  rvv_dispatch_pkg::rob_entry_t [rvv_dispatch_pkg::rob_depth-1:0] rob_entries,
    output rvv_dispatch_pkg::src_hit_t                             hit
);
    import rvv_dispatch_pkg::*;

    // Walk from the oldest slot to the youngest, so the last match wins
    function automatic void find_youngest(
        input  vreg_idx_t                    src,
        input  rob_idx_t                     tail,
        input  rob_entry_t [rob_depth-1:0]   entries,
        output logic                         found,
        output rob_idx_t                     idx
    );
        rob_idx_t slot;
        found = 1'b0;
        idx   = '0;
        for (int k = rob_depth; k >= 1; k--) begin
            slot = tail - rob_idx_t'(k);
            if (entries[slot].valid && (entries[slot].w_index == src)) begin
                found = 1'b1;
                idx   = slot;
            end
        end
    endfunction

    always_comb begin
        src_use_t rd;
        logic     vs1_found;
        logic     vs2_found;
        logic     vd_found;
        rob_idx_t vs1_slot;
        rob_idx_t vs2_slot;
        rob_idx_t vd_slot;

        rd = src_used(uop.uop_class);
        find_youngest(uop.vs1, rob_tail, rob_entries, vs1_found, vs1_slot);
        find_youngest(uop.vs2, rob_tail, rob_entries, vs2_found, vs2_slot);
        find_youngest(uop.vd, rob_tail, rob_entries, vd_found, vd_slot);

        // Sources the class does not read never hit
        hit.vs1_hit = vs1_found & rd.vs1;
        hit.vs1_idx = vs1_slot;
        hit.vs2_hit = vs2_found & rd.vs2;
        hit.vs2_idx = vs2_slot;
        hit.vd_hit  = vd_found & rd.vd;
        hit.vd_idx  = vd_slot;

        // Producer found but result not written back yet
        hit.stall = (hit.vs1_hit & ~rob_entries[hit.vs1_idx].w_valid) |
                    (hit.vs2_hit & ~rob_entries[hit.vs2_idx].w_valid) |
                    (hit.vd_hit  & ~rob_entries[hit.vd_idx].w_valid);
    end

    a_hit_on_valid_entry: assert property (@(posedge clk) disable iff (!rst_n)
        (!hit.vs1_hit || rob_entries[hit.vs1_idx].valid) &&
        (!hit.vs2_hit || rob_entries[hit.vs2_idx].valid) &&
        (!hit.vd_hit  || rob_entries[hit.vd_idx].valid));

endmodule

/* dispatch_hazard/vrf_read_arbiter.sv */
// Hands out the four VRF read ports in order uop0 vs2, vs1, vd, then uop1.
// Demand is counted from uop_class alone, whether or not the uop is valid.
module vrf_read_arbiter (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  rvv_dispatch_pkg::uop_t [rvv_dispatch_pkg::num_dp_uop-1:0] uop,
    output rvv_dispatch_pkg::vreg_idx_t [rvv_dispatch_pkg::num_vrf_rd-1:0] vrf_rd_index,
    output rvv_dispatch_pkg::port_sel_t [rvv_dispatch_pkg::num_dp_uop-1:0] port_sel,
    output logic                                                   strct_hazard
);
    import rvv_dispatch_pkg::*;

    logic [2:0]            demand [num_dp_uop];
    logic [num_vrf_rd-1:0] granted;
    logic                  dup_grant;

    always_comb begin
        src_use_t rd;
        for (int i = 0; i < num_dp_uop; i++) begin
            rd        = src_used(uop[i].uop_class);
            demand[i] = 3'(rd.vs2) + 3'(rd.vs1) + 3'(rd.vd);
        end
    end

    // uop0 needs at most three ports, so only uop1 can be refused
    assign strct_hazard = (4'(demand[0]) + 4'(demand[1])) > 4'(num_vrf_rd);

    always_comb begin
        logic [2:0] ptr;
        src_use_t   rd;
        logic [2:0] rd_vec;
        vreg_idx_t  src_idx [3];
        vrf_port_t  sel [3];

        ptr          = '0;
        granted      = '0;
        dup_grant    = 1'b0;
        vrf_rd_index = '0;
        port_sel     = '0;

        for (int i = 0; i < num_dp_uop; i++) begin
            rd         = src_used(uop[i].uop_class);
            rd_vec     = {rd.vd, rd.vs1, rd.vs2};
            src_idx[0] = uop[i].vs2;
            src_idx[1] = uop[i].vs1;
            src_idx[2] = uop[i].vd;
            for (int j = 0; j < 3; j++) begin
                sel[j] = '0;
            end
            if ((i == 0) || !strct_hazard) begin
                for (int j = 0; j < 3; j++) begin
                    if (rd_vec[j]) begin
                        dup_grant = dup_grant | granted[vrf_port_t'(ptr)];
                        granted[vrf_port_t'(ptr)]      = 1'b1;
                        vrf_rd_index[vrf_port_t'(ptr)] = src_idx[j];
                        sel[j] = vrf_port_t'(ptr);
                        ptr    = ptr + 3'd1;
                    end
                end
            end
            port_sel[i].vs2_port = sel[0];
            port_sel[i].vs1_port = sel[1];
            port_sel[i].vd_port  = sel[2];
        end
    end

    // Catches a demand count that lets the grant pointer wrap
    a_no_double_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !dup_grant);

endmodule

/* project.f */
+incdir+verification
common/rvv_dispatch_pkg.sv
dispatch_hazard/raw_rob_check.sv
dispatch_hazard/vrf_read_arbiter.sv
rtl/operand_bypass.sv
rtl/dispatch_ctrl.sv
rtl/rvv_dispatch.sv
verification/tb_rvv_dispatch.sv

/* rtl/dispatch_ctrl.sv */
// In-order issue of up to two uops; all valid and ready outputs are held low in reset.
module dispatch_ctrl (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]                uop_valid,
    input  rvv_dispatch_pkg::uop_t [rvv_dispatch_pkg::num_dp_uop-1:0] uop,
    input  rvv_dispatch_pkg::src_hit_t [rvv_dispatch_pkg::num_dp_uop-1:0] hit,
    input  logic                                                   strct_hazard,
    input  rvv_dispatch_pkg::uop_opnd_t [rvv_dispatch_pkg::num_dp_uop-1:0] opnd,
    input  rvv_dispatch_pkg::rob_idx_t                             rob_tail,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rs_ready_alu,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rs_ready_mul,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rob_push_ready,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]                uop_ready,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rs_valid_alu,
    output rvv_dispatch_pkg::alu_rs_t [rvv_dispatch_pkg::num_dp_uop-1:0] rs_alu,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rs_valid_mul,
    output rvv_dispatch_pkg::mul_rs_t [rvv_dispatch_pkg::num_dp_uop-1:0] rs_mul,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]                rob_push_valid,
    output rvv_dispatch_pkg::dp2rob_t [rvv_dispatch_pkg::num_dp_uop-1:0] rob_push
);
    import rvv_dispatch_pkg::*;

    src_use_t [num_dp_uop-1:0] rd_src;
    logic     [num_dp_uop-1:0] unit_ready;
    logic     [num_dp_uop-1:0] can_issue;
    alu_rs_t  [num_dp_uop-1:0] rs_pay;
    logic                      dep_uop0;

    always_comb begin
        for (int i = 0; i < num_dp_uop; i++) begin
            rd_src[i]     = src_used(uop[i].uop_class);
            unit_ready[i] = (uop[i].exe_unit == MUL) ? rs_ready_mul[i] : rs_ready_alu[i];
        end
    end

    // uop1 reads what uop0 is about to write
    assign dep_uop0 = (rd_src[1].vs2 && (uop[1].vs2 == uop[0].vd)) ||
                      (rd_src[1].vs1 && (uop[1].vs1 == uop[0].vd)) ||
                      (rd_src[1].vd  && (uop[1].vd  == uop[0].vd));

    // Nothing issues while in reset
    assign can_issue[0] = rst_n && uop_valid[0] && !hit[0].stall &&
                          unit_ready[0] && rob_push_ready[0];

    // Lane 1 only ever goes behind lane 0
    assign can_issue[1] = can_issue[0] && uop_valid[1] && !hit[1].stall &&
                          !strct_hazard && !dep_uop0 &&
                          unit_ready[1] && rob_push_ready[1];

    for (genvar i = 0; i < num_dp_uop; i++) begin : gen_lane
        assign uop_ready[i]      = can_issue[i];
        assign rob_push_valid[i] = can_issue[i];
        assign rs_valid_alu[i]   = can_issue[i] && (uop[i].exe_unit == ALU);
        assign rs_valid_mul[i]   = can_issue[i] && (uop[i].exe_unit == MUL);

        always_comb begin
            rs_pay[i].rob_entry      = rob_tail + rob_idx_t'(i);
            rs_pay[i].funct6         = uop[i].funct6;
            rs_pay[i].funct3         = uop[i].funct3;
            rs_pay[i].vm             = uop[i].vm;
            rs_pay[i].vs1_data       = opnd[i].vs1;
            rs_pay[i].vs1_data_valid = rd_src[i].vs1;
            rs_pay[i].vs2_data       = opnd[i].vs2;
            rs_pay[i].vs2_data_valid = rd_src[i].vs2;
            rs_pay[i].vd_data        = opnd[i].vd;
            rs_pay[i].vd_data_valid  = rd_src[i].vd;
            rs_pay[i].rs1_data       = uop[i].rs1_data;
        end

        // Both stations see the payload, only the valid steers it
        assign rs_alu[i] = rs_pay[i];
        assign rs_mul[i] = rs_pay[i];

        assign rob_push[i].w_index  = uop[i].vd;
        assign rob_push[i].last_uop = uop[i].last_uop;
    end

    a_in_order_issue: assert property (@(posedge clk) disable iff (!rst_n)
        uop_ready[1] |-> uop_ready[0]);

endmodule

/* rtl/operand_bypass.sv */
// Operand select for one uop; a ROB hit always wins over the VRF port.
module operand_bypass (
    input  rvv_dispatch_pkg::src_hit_t                             hit,
    input  rvv_dispatch_pkg::port_sel_t                            port_sel,
    input  rvv_dispatch_pkg::vlen_t [rvv_dispatch_pkg::num_vrf_rd-1:0] vrf_rd_data,
    input  rvv_dispatch_pkg::rob_entry_t [rvv_dispatch_pkg::rob_depth-1:0] rob_entries,
    output rvv_dispatch_pkg::uop_opnd_t                            opnd
);
    import rvv_dispatch_pkg::*;

    vlen_t vs1_fwd;
    vlen_t vs2_fwd;
    vlen_t vd_fwd;

    // Forwarded results of the youngest producers
    assign vs1_fwd = rob_entries[hit.vs1_idx].w_data;
    assign vs2_fwd = rob_entries[hit.vs2_idx].w_data;
    assign vd_fwd  = rob_entries[hit.vd_idx].w_data;

    assign opnd.vs1 = hit.vs1_hit ? vs1_fwd : vrf_rd_data[port_sel.vs1_port];
    assign opnd.vs2 = hit.vs2_hit ? vs2_fwd : vrf_rd_data[port_sel.vs2_port];
    assign opnd.vd  = hit.vd_hit  ? vd_fwd  : vrf_rd_data[port_sel.vd_port];

endmodule

/* rtl/rvv_dispatch.sv */
// Combinational two-wide dispatch; VRF read data must return in the same cycle.
// clk only clocks the embedded assertions, and rst_n low holds every valid and ready low.
module rvv_dispatch (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]               uop_valid,
    input  rvv_dispatch_pkg::uop_t [rvv_dispatch_pkg::num_dp_uop-1:0] uop,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]               uop_ready,
    input  rvv_dispatch_pkg::rob_idx_t                            rob_tail,
    input  rvv_dispatch_pkg::rob_entry_t [rvv_dispatch_pkg::rob_depth-1:0] rob_entries,
    output rvv_dispatch_pkg::vreg_idx_t [rvv_dispatch_pkg::num_vrf_rd-1:0] vrf_rd_index,
    input  rvv_dispatch_pkg::vlen_t [rvv_dispatch_pkg::num_vrf_rd-1:0] vrf_rd_data,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rs_valid_alu,
    output rvv_dispatch_pkg::alu_rs_t [rvv_dispatch_pkg::num_dp_uop-1:0] rs_alu,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rs_ready_alu,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rs_valid_mul,
    output rvv_dispatch_pkg::mul_rs_t [rvv_dispatch_pkg::num_dp_uop-1:0] rs_mul,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rs_ready_mul,
    output logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rob_push_valid,
    output rvv_dispatch_pkg::dp2rob_t [rvv_dispatch_pkg::num_dp_uop-1:0] rob_push,
    input  logic [rvv_dispatch_pkg::num_dp_uop-1:0]               rob_push_ready
);
    import rvv_dispatch_pkg::*;

    src_hit_t  [num_dp_uop-1:0] hit;
    port_sel_t [num_dp_uop-1:0] port_sel;
    uop_opnd_t [num_dp_uop-1:0] opnd;
    logic                       strct_hazard;

    for (genvar i = 0; i < num_dp_uop; i++) begin : gen_lane
        raw_rob_check u_raw_rob_check (
            .clk         (clk),
            .rst_n       (rst_n),
            .uop         (uop[i]),
            .rob_tail    (rob_tail),
            .rob_entries (rob_entries),
            .hit         (hit[i])
        );

        operand_bypass u_operand_bypass (
            .hit         (hit[i]),
            .port_sel    (port_sel[i]),
            .vrf_rd_data (vrf_rd_data),
            .rob_entries (rob_entries),
            .opnd        (opnd[i])
        );
    end

    vrf_read_arbiter u_vrf_read_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop          (uop),
        .vrf_rd_index (vrf_rd_index),
        .port_sel     (port_sel),
        .strct_hazard (strct_hazard)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .uop_valid      (uop_valid),
        .uop            (uop),
        .hit            (hit),
        .strct_hazard   (strct_hazard),
        .opnd           (opnd),
        .rob_tail       (rob_tail),
        .rs_ready_alu   (rs_ready_alu),
        .rs_ready_mul   (rs_ready_mul),
        .rob_push_ready (rob_push_ready),
        .uop_ready      (uop_ready),
        .rs_valid_alu   (rs_valid_alu),
        .rs_alu         (rs_alu),
        .rs_valid_mul   (rs_valid_mul),
        .rs_mul         (rs_mul),
        .rob_push_valid (rob_push_valid),
        .rob_push       (rob_push)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log
verilator --binary --timing --assert -f project.f --top-module tb_rvv_dispatch \
    -o tb_rvv_dispatch > build.log 2>&1 \
    && ./obj_dir/tb_rvv_dispatch > sim.log 2>&1 \
    || { cat build.log sim.log 2> /dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

/* verification/dispatch_ref_model.svh */
// Reference model of the dispatch rules, included inside the testbench module.
// check_value counts into n_checks and n_errors and names cur_test of the includer.
`ifndef DISPATCH_REF_MODEL_SVH
`define DISPATCH_REF_MODEL_SVH

// Sources read per class as {vd, vs1, vs2}
function automatic logic [2:0] class_reads(input uop_class_e cls);
    case (cls)
        VVV:     return 3'b111;
        VV:      return 3'b011;
        default: return 3'b001;
    endcase
endfunction

// VRF contents, every index bit shows in the word
function automatic vlen_t vrf_word(input vreg_idx_t idx);
    return {32'h9e37_79b9 * {27'd0, idx}, ~{27'd0, idx} ^ 32'h0f1e_2d3c};
endfunction

// First valid entry writing src, searching back from tail-1
function automatic void youngest_producer(input vreg_idx_t src, input rob_idx_t tail,
                                          input rob_entry_t [rob_depth-1:0] e,
                                          output logic found, output rob_idx_t idx);
    rob_idx_t slot;
    found = 1'b0;
    idx   = '0;
    for (int k = 1; k <= rob_depth; k++) begin
        slot = tail - rob_idx_t'(k);
        if (!found && e[slot].valid && (e[slot].w_index == src)) begin
            found = 1'b1;
            idx   = slot;
        end
    end
endfunction

function automatic vlen_t expect_operand(input vreg_idx_t src, input rob_idx_t tail,
                                         input rob_entry_t [rob_depth-1:0] e);
    logic     found;
    rob_idx_t idx;
    youngest_producer(src, tail, e, found, idx);
    return found ? e[idx].w_data : vrf_word(src);
endfunction

// A read source whose youngest producer has not written back
function automatic logic expect_stall(input uop_t u, input rob_idx_t tail,
                                      input rob_entry_t [rob_depth-1:0] e);
    logic [2:0] r;
    vreg_idx_t  src [3];
    logic       found;
    rob_idx_t   idx;
    logic       stall;
    r     = class_reads(u.uop_class);
    src   = '{u.vs2, u.vs1, u.vd};
    stall = 1'b0;
    for (int j = 0; j < 3; j++) begin
        youngest_producer(src[j], tail, e, found, idx);
        stall = stall | (r[j] & found & ~e[idx].w_valid);
    end
    return stall;
endfunction

// Ports go to uop0 vs2, vs1, vd, then to uop1 only when the total fits
function automatic void expect_ports(input uop_t [1:0] u,
                                     output vreg_idx_t [num_vrf_rd-1:0] idx,
                                     output logic hazard);
    logic [2:0] r [2];
    vreg_idx_t  src [3];
    int         n;
    r[0]   = class_reads(u[0].uop_class);
    r[1]   = class_reads(u[1].uop_class);
    hazard = ($countones(r[0]) + $countones(r[1])) > num_vrf_rd;
    idx    = '0;
    n      = 0;
    for (int i = 0; i < 2; i++) begin
        src = '{u[i].vs2, u[i].vs1, u[i].vd};
        for (int j = 0; j < 3; j++) begin
            if (r[i][j] && ((i == 0) || !hazard)) begin
                idx[n] = src[j];
                n++;
            end
        end
    end
endfunction

function automatic logic [1:0] expect_issue(input logic [1:0] valid, input uop_t [1:0] u,
                                            input logic [1:0] stall, input logic hazard,
                                            input logic [1:0] rdy_alu, input logic [1:0] rdy_mul,
                                            input logic [1:0] push_rdy);
    logic [1:0] unit_rdy;
    logic [2:0] r1;
    logic       dep;
    logic [1:0] go;
    for (int i = 0; i < 2; i++) begin
        unit_rdy[i] = (u[i].exe_unit == MUL) ? rdy_mul[i] : rdy_alu[i];
    end
    r1  = class_reads(u[1].uop_class);
    dep = (r1[0] && (u[1].vs2 == u[0].vd)) || (r1[1] && (u[1].vs1 == u[0].vd)) ||
          (r1[2] && (u[1].vd == u[0].vd));
    go[0] = valid[0] && !stall[0] && unit_rdy[0] && push_rdy[0];
    go[1] = go[0] && valid[1] && !stall[1] && !hazard && !dep && unit_rdy[1] && push_rdy[1];
    return go;
endfunction

task automatic check_value(input string what, input vlen_t exp, input vlen_t act);
    n_checks++;
    if (exp !== act) begin
        n_errors++;
        $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

`endif

/* verification/tb_rvv_dispatch.sv */
// Random-stimulus testbench for the two-wide dispatch stage with ROB and VRF models.
// Inputs change 5 ns after the rising edge and outputs are checked 45 ns after it.
module tb_rvv_dispatch;
    timeunit 1ns;
    timeprecision 100ps;
    import rvv_dispatch_pkg::*;

    logic                        clk;
    logic                        rst_n;
    logic       [num_dp_uop-1:0] uop_valid;
    logic       [num_dp_uop-1:0] uop_ready;
    uop_t       [num_dp_uop-1:0] uop;
    rob_idx_t                    rob_tail;
    rob_entry_t [rob_depth-1:0]  rob_entries;
    vreg_idx_t  [num_vrf_rd-1:0] vrf_rd_index;
    vlen_t      [num_vrf_rd-1:0] vrf_rd_data;
    logic       [num_dp_uop-1:0] rs_valid_alu;
    logic       [num_dp_uop-1:0] rs_ready_alu;
    logic       [num_dp_uop-1:0] rs_valid_mul;
    logic       [num_dp_uop-1:0] rs_ready_mul;
    logic       [num_dp_uop-1:0] rob_push_valid;
    logic       [num_dp_uop-1:0] rob_push_ready;
    alu_rs_t    [num_dp_uop-1:0] rs_alu;
    mul_rs_t    [num_dp_uop-1:0] rs_mul;
    dp2rob_t    [num_dp_uop-1:0] rob_push;
    int                          n_checks;
    int                          n_errors;
    string                       cur_test;

    `include "dispatch_ref_model.svh"

    rvv_dispatch u_rvv_dispatch (.*);

    // VRF answers in the same cycle
    for (genvar p = 0; p < num_vrf_rd; p++) begin : gen_vrf
        assign vrf_rd_data[p] = vrf_word(vrf_rd_index[p]);
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Register indices stay in 0..7 so ROB hits are frequent
    function automatic uop_t rand_uop(input int cls);
        uop_t        u;
        logic [63:0] raw;
        raw         = {$urandom, $urandom};
        u           = raw[$bits(uop_t)-1:0];
        u.uop_class = uop_class_e'(2'((cls < 0) ? $urandom_range(0, 2) : cls));
        u.vs1       = vreg_idx_t'($urandom_range(0, 7));
        u.vs2       = vreg_idx_t'($urandom_range(0, 7));
        u.vd        = vreg_idx_t'($urandom_range(0, 7));
        return u;
    endfunction

    // A negative class picks one at random
    task automatic drive(input int cls0, input int cls1, input logic quiet_rob,
                         input logic make_dep, input logic rand_rdy);
        @(posedge clk);
        #5;
        for (int k = 0; k < rob_depth; k++) begin
            rob_entries[k].valid   = !quiet_rob && ($urandom_range(0, 3) != 0);
            rob_entries[k].w_valid = $urandom_range(0, 2) != 0;
            rob_entries[k].w_index = vreg_idx_t'($urandom_range(0, 7));
            rob_entries[k].w_data  = {$urandom, $urandom};
        end
        rob_tail = rob_idx_t'($urandom_range(0, rob_depth - 1));
        uop[0]   = rand_uop(cls0);
        uop[1]   = rand_uop(cls1);
        if (make_dep) begin
            uop[1].vs2 = uop[0].vd;
        end
        uop_valid      = rand_rdy ? 2'($urandom_range(0, 3)) : 2'b11;
        rs_ready_alu   = rand_rdy ? 2'($urandom_range(0, 3)) : 2'b11;
        rs_ready_mul   = rand_rdy ? 2'($urandom_range(0, 3)) : 2'b11;
        rob_push_ready = rand_rdy ? 2'($urandom_range(0, 3)) : 2'b11;
        #40;
    endtask

    task automatic check_lane(input int i);
        alu_rs_t    pay;
        logic [2:0] r;
        rob_idx_t   exp_entry;
        string      tag;
        pay       = (uop[i].exe_unit == MUL) ? rs_mul[i] : rs_alu[i];
        r         = class_reads(uop[i].uop_class);
        exp_entry = rob_tail + rob_idx_t'(i);
        tag       = $sformatf("lane%0d", i);
        check_value({tag, " rob_entry"}, vlen_t'(exp_entry), vlen_t'(pay.rob_entry));
        check_value({tag, " fields"},
                    vlen_t'({uop[i].funct6, uop[i].funct3, uop[i].vm, uop[i].rs1_data}),
                    vlen_t'({pay.funct6, pay.funct3, pay.vm, pay.rs1_data}));
        check_value({tag, " data_valid"}, vlen_t'(r),
                    vlen_t'({pay.vd_data_valid, pay.vs1_data_valid, pay.vs2_data_valid}));
        if (r[0]) begin
            check_value({tag, " vs2"}, expect_operand(uop[i].vs2, rob_tail, rob_entries),
                        pay.vs2_data);
        end
        if (r[1]) begin
            check_value({tag, " vs1"}, expect_operand(uop[i].vs1, rob_tail, rob_entries),
                        pay.vs1_data);
        end
        if (r[2]) begin
            check_value({tag, " vd"}, expect_operand(uop[i].vd, rob_tail, rob_entries),
                        pay.vd_data);
        end
        check_value({tag, " rob_push"}, vlen_t'({uop[i].vd, uop[i].last_uop}),
                    vlen_t'(rob_push[i]));
    endtask

    task automatic check_outputs();
        vreg_idx_t [num_vrf_rd-1:0] exp_idx;
        logic                       hazard;
        logic [1:0]                 stall;
        logic [1:0]                 go;
        logic [1:0]                 to_mul;
        logic [1:0]                 to_alu;
        expect_ports(uop, exp_idx, hazard);
        check_value("vrf_rd_index", vlen_t'(exp_idx), vlen_t'(vrf_rd_index));
        for (int i = 0; i < 2; i++) begin
            stall[i] = expect_stall(uop[i], rob_tail, rob_entries);
        end
        go     = expect_issue(uop_valid, uop, stall, hazard, rs_ready_alu, rs_ready_mul,
                              rob_push_ready);
        to_mul = {uop[1].exe_unit == MUL, uop[0].exe_unit == MUL};
        to_alu = go & ~to_mul;
        to_mul = go & to_mul;
        check_value("uop_ready", vlen_t'(go), vlen_t'(uop_ready));
        check_value("rob_push_valid", vlen_t'(go), vlen_t'(rob_push_valid));
        check_value("rs_valid_alu", vlen_t'(to_alu), vlen_t'(rs_valid_alu));
        check_value("rs_valid_mul", vlen_t'(to_mul), vlen_t'(rs_valid_mul));
        for (int i = 0; i < 2; i++) begin
            if (go[i]) begin
                check_lane(i);
            end
        end
    endtask

    // uop0 of a clean pair must be taken within a few cycles
    task automatic wait_uop0_issue();
        int cycles;
        cycles = 0;
        while (!uop_ready[0] && (cycles < 4)) begin
            @(negedge clk);
            cycles++;
        end
        if (!uop_ready[0]) begin
            n_errors++;
            $display("Timeout in %s: uop0 was never accepted by the dispatch stage", cur_test);
        end
    endtask

    task automatic report_test(input int err_before);
        $display("%s finished, %0d errors", cur_test, n_errors - err_before);
    endtask

    initial begin
        int err_before;
        void'($urandom(32'h64c6));
        n_checks       = 0;
        n_errors       = 0;
        rst_n          = 1'b0;
        uop            = '0;
        rob_tail       = '0;
        rob_entries    = '0;
        // A clean pair with every ready high, so only rst_n can hold it back
        uop_valid      = '1;
        rs_ready_alu   = '1;
        rs_ready_mul   = '1;
        rob_push_ready = '1;

        cur_test   = "reset";
        err_before = n_errors;
        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            #45;
            check_value("uop_ready", '0, vlen_t'(uop_ready));
            check_value("rs_valid_alu", '0, vlen_t'(rs_valid_alu));
            check_value("rs_valid_mul", '0, vlen_t'(rs_valid_mul));
            check_value("rob_push_valid", '0, vlen_t'(rob_push_valid));
        end
        @(posedge clk);
        #5;
        rst_n = 1'b1;
        report_test(err_before);

        cur_test   = "rob_forwarding";
        err_before = n_errors;
        for (int k = 0; k < 300; k++) begin
            drive(-1, -1, 1'b0, 1'b0, 1'b0);
            check_outputs();
        end
        report_test(err_before);

        // VVV with VV or VVV needs five or six ports
        cur_test   = "structure_hazard";
        err_before = n_errors;
        for (int k = 0; k < 40; k++) begin
            drive(0, int'($urandom_range(0, 1)), 1'b1, 1'b0, 1'b0);
            check_outputs();
            wait_uop0_issue();
        end
        report_test(err_before);

        // VX then VV or VX, so only the dependency can hold uop1
        cur_test   = "uop_dependency";
        err_before = n_errors;
        for (int k = 0; k < 40; k++) begin
            drive(2, int'($urandom_range(1, 2)), 1'b1, 1'b1, 1'b0);
            check_outputs();
            wait_uop0_issue();
        end
        report_test(err_before);

        cur_test   = "back_pressure";
        err_before = n_errors;
        for (int k = 0; k < 300; k++) begin
            drive(-1, -1, 1'b0, 1'b0, 1'b1);
            check_outputs();
        end
        report_test(err_before);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
